//--- build.f
+incdir+.
mps_types_pkg.sv
mps_regs_pkg.sv
mps_reg_bank.sv
mps_intl_monitor.sv
mps_system_fsm.sv
mps_on_sequencer.sv
mps_off_sequencer.sv
mps_system_top.sv
tb_mps_system.sv

//--- tb_mps_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "mps_config.svh"

module tb_mps_system;

	localparam int MAX_CYCLES = 5000;		// Six tests of about 300 cycles each with ample margin
	localparam int RUN_BOUND = 2 * `MPS_ON_TIMEOUT + `MPS_FAN_DELAY + 20;

	logic						i_clk;
	logic						i_rst;
	logic						i_wr;
	logic						i_rd;
	logic [`MPS_ADDR_W-1:0]		i_addr;
	logic [`MPS_DATA_W-1:0]		i_wdata;
	wire [`MPS_DATA_W-1:0]		o_rdata;
	wire						o_rvalid;
	logic [17:0]				i_analog_intl;
	logic						i_duty_intl;
	logic [15:0]				i_ext_di;
	logic [31:0]				i_dc_v;
	wire						o_pwm_en;
	wire						o_intl_flag;
	wire [7:0]					o_ext_do;

	string cur_test;
	int test_errors;
	int total_errors;
	int tests_passed;
	int tests_failed;
	int cycle_count;
	int unsigned seed_val;

	mps_system_top DUT
	(
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_wr			(i_wr),
		.i_rd			(i_rd),
		.i_addr			(i_addr),
		.i_wdata		(i_wdata),
		.o_rdata		(o_rdata),
		.o_rvalid		(o_rvalid),
		.i_analog_intl	(i_analog_intl),
		.i_duty_intl	(i_duty_intl),
		.i_ext_di		(i_ext_di),
		.i_dc_v			(i_dc_v),
		.o_pwm_en		(o_pwm_en),
		.o_intl_flag	(o_intl_flag),
		.o_ext_do		(o_ext_do)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Expected REG_STATUS layout
	function automatic logic [31:0] status_word(input logic [2:0] st, input logic pwm);
		status_word = '0;
		status_word[2:0] = st;
		status_word[8] = pwm;
	endfunction

	function automatic logic [31:0] seq_word(input logic [3:0] on_st, input logic [3:0] off_st,
			input logic [3:0] fail_code);
		seq_word = '0;
		seq_word[3:0] = on_st;
		seq_word[7:4] = off_st;
		seq_word[11:8] = fail_code;
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
		else
		begin
			$display("Fail %s: %s expected %0h, actual %0h", cur_test, what, exp, got);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
		@(negedge i_clk);
		i_wr = 1'b1;
		i_addr = addr;
		i_wdata = data;
		@(negedge i_clk);
		i_wr = 1'b0;
		i_wdata = '0;
	endtask

	task automatic reg_read(input logic [4:0] addr, output logic [31:0] data);
		int waited;
		@(negedge i_clk);
		i_rd = 1'b1;
		i_addr = addr;
		@(negedge i_clk);
		i_rd = 1'b0;
		waited = 0;
		while (!o_rvalid && waited < 4)
		begin
			@(negedge i_clk);
			waited = waited + 1;
		end
		assert (o_rvalid)
		else
		begin
			$display("%s: read of address %0d got no response", cur_test, addr);
			test_errors = test_errors + 1;
		end
		data = o_rdata;
	endtask

	// Each status read costs two cycles
	task automatic wait_state(input logic [2:0] st, input int max_cycles);
		logic [31:0] word;
		int spent;
		spent = 0;
		reg_read(mps_regs_pkg::REG_STATUS, word);
		while (word[2:0] != st && spent < max_cycles)
		begin
			reg_read(mps_regs_pkg::REG_STATUS, word);
			spent = spent + 2;
		end
		assert (word[2:0] == st)
		else
		begin
			$display("%s: state did not reach %0d within %0d cycles, last state %0d",
				cur_test, st, max_cycles, word[2:0]);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic bring_to_run();
		i_dc_v = `MPS_DCV_READY + 500;
		i_ext_di = 16'h0002;					// Main contactor feedback
		reg_write(mps_regs_pkg::REG_CMD, mps_types_pkg::CMD_READY);
		wait_state(mps_types_pkg::SYS_READY, 10);
		reg_write(mps_regs_pkg::REG_CMD, mps_types_pkg::CMD_OP_ON);
		wait_state(mps_types_pkg::SYS_RUN, RUN_BOUND);
	endtask

	task automatic clear_to_off();
		reg_write(mps_regs_pkg::REG_CMD, mps_types_pkg::CMD_INTL_CLR);
		wait_state(mps_types_pkg::SYS_OFF, 10);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0)
		begin
			$display("%s: passed", cur_test);
			tests_passed = tests_passed + 1;
		end
		else
		begin
			$display("%s: failed with %0d errors", cur_test, test_errors);
			tests_failed = tests_failed + 1;
		end
		total_errors = total_errors + test_errors;
	endtask

	task automatic test_reset_and_ext_do();
		logic [31:0] word;
		logic [4:0] val;
		start_test("reset_and_ext_do");
		reg_read(mps_regs_pkg::REG_STATUS, word);
		compare("status after reset", status_word(mps_types_pkg::SYS_OFF, 1'b0), word);
		compare("o_ext_do after reset", 32'h0, {24'h0, o_ext_do});
		val = 5'($urandom);
		reg_write(mps_regs_pkg::REG_EXT_DO, {27'h0, val});
		reg_read(mps_regs_pkg::REG_EXT_DO, word);
		compare("EXT_DO readback", {27'h0, val}, word);
		compare("o_ext_do upper bits", {27'h0, val}, {27'h0, o_ext_do[7:3]});
		end_test();
	endtask

	task automatic test_power_up();
		logic [31:0] word;
		start_test("power_up");
		bring_to_run();
		compare("pwm enable", 32'h1, {31'h0, o_pwm_en});
		compare("contactors", 32'h7, {29'h0, o_ext_do[2:0]});
		reg_read(mps_regs_pkg::REG_STATUS, word);
		compare("status in run", status_word(mps_types_pkg::SYS_RUN, 1'b1), word);
		reg_read(mps_regs_pkg::REG_SEQ, word);
		compare("sequencer word", seq_word(4'd0, 4'd0, mps_types_pkg::FAIL_NONE), word);
		end_test();
	endtask

	task automatic test_power_down();
		start_test("power_down");
		reg_write(mps_regs_pkg::REG_CMD, mps_types_pkg::CMD_OP_OFF);
		wait_state(mps_types_pkg::SYS_OFF_SEQ, 10);
		compare("pwm in off sequence", 32'h0, {31'h0, o_pwm_en});
		compare("contactors held", 32'h7, {29'h0, o_ext_do[2:0]});
		i_dc_v = `MPS_DCV_SAFE - 40;			// Link discharged
		wait_state(mps_types_pkg::SYS_OFF, `MPS_MC_DELAY + 20);
		compare("pwm after off", 32'h0, {31'h0, o_pwm_en});
		compare("contactors open", 32'h0, {29'h0, o_ext_do[2:0]});
		end_test();
	endtask

	task automatic test_precharge_fail();
		logic [31:0] word;
		start_test("precharge_fail");
		i_dc_v = 32'd0;
		reg_write(mps_regs_pkg::REG_CMD, mps_types_pkg::CMD_READY);
		wait_state(mps_types_pkg::SYS_READY, 10);
		reg_write(mps_regs_pkg::REG_CMD, mps_types_pkg::CMD_OP_ON);
		wait_state(mps_types_pkg::SYS_INTL, `MPS_ON_TIMEOUT + 20);
		reg_read(mps_regs_pkg::REG_SEQ, word);
		compare("failure code", seq_word(4'd0, 4'd0, mps_types_pkg::FAIL_PRECHARGE), word);
		reg_read(mps_regs_pkg::REG_STATUS, word);
		compare("status in interlock", status_word(mps_types_pkg::SYS_INTL, 1'b0), word);
		compare("contactors", 32'h0, {29'h0, o_ext_do[2:0]});
		clear_to_off();
		reg_read(mps_regs_pkg::REG_SEQ, word);
		compare("failure code kept", seq_word(4'd0, 4'd0, mps_types_pkg::FAIL_PRECHARGE), word);
		end_test();
	endtask

	task automatic test_analog_intl();
		logic [31:0] word;
		start_test("analog_intl");
		bring_to_run();
		@(negedge i_clk);
		i_analog_intl = 18'h00080;
		wait_state(mps_types_pkg::SYS_INTL, 10);
		compare("interlock flag", 32'h1, {31'h0, o_intl_flag});
		compare("pwm enable", 32'h0, {31'h0, o_pwm_en});
		compare("contactors", 32'h0, {29'h0, o_ext_do[2:0]});
		reg_read(mps_regs_pkg::REG_ANA_INTL, word);
		compare("analog readback", 32'h00080, word);
		@(negedge i_clk);
		i_analog_intl = '0;
		@(negedge i_clk);
		clear_to_off();
		end_test();
	endtask

	task automatic test_duty_intl();
		logic [31:0] word;
		start_test("duty_intl");
		bring_to_run();
		@(negedge i_clk);
		i_duty_intl = 1'b1;
		@(negedge i_clk);
		i_duty_intl = 1'b0;
		wait_state(mps_types_pkg::SYS_INTL, 10);
		reg_read(mps_regs_pkg::REG_ANA_INTL, word);
		compare("duty latch set", 32'h1 << 18, word);
		repeat (5) @(negedge i_clk);
		reg_read(mps_regs_pkg::REG_ANA_INTL, word);
		compare("duty latch held", 32'h1 << 18, word);
		clear_to_off();
		reg_read(mps_regs_pkg::REG_ANA_INTL, word);
		compare("duty latch cleared", 32'h0, word);
		end_test();
	endtask

	initial
	begin
		i_rst = 1'b0;
		i_wr = 1'b0;
		i_rd = 1'b0;
		i_addr = '0;
		i_wdata = '0;
		i_analog_intl = '0;
		i_duty_intl = 1'b0;
		i_ext_di = '0;
		i_dc_v = '0;
		cycle_count = 0;
		test_errors = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		cur_test = "none";
		seed_val = $urandom(82);
		repeat (10) @(negedge i_clk);
		i_rst = 1'b1;

		test_reset_and_ext_do();
		test_power_up();
		test_power_down();						// Continues from run
		test_precharge_fail();
		test_analog_intl();
		test_duty_intl();

		$display("Tests passed %0d, failed %0d, check errors %0d",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0 && total_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- mps_system_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mps_config.svh"

module mps_system_top
(
	input  wire							i_clk,
	input  wire							i_rst,

	input  wire							i_wr,
	input  wire							i_rd,
	input  wire [`MPS_ADDR_W-1:0]		i_addr,
	input  wire [`MPS_DATA_W-1:0]		i_wdata,
	output wire [`MPS_DATA_W-1:0]		o_rdata,
	output wire							o_rvalid,

	input  wire [17:0]					i_analog_intl,
	input  wire							i_duty_intl,
	input  wire [15:0]					i_ext_di,
	input  wire [31:0]					i_dc_v,

	output wire							o_pwm_en,
	output wire							o_intl_flag,
	output wire [7:0]					o_ext_do
);

	mps_types_pkg::sys_state_t sys_state;
	mps_types_pkg::cmd_t cmd;
	mps_types_pkg::on_step_t on_step;
	mps_types_pkg::off_step_t off_step;
	mps_types_pkg::fail_t fail;

	wire cmd_valid;
	wire intl_clr;
	wire duty_latch;
	wire [4:0] ext_do_reg;
	wire on_start;
	wire off_start;
	wire seq_abort;
	wire on_done;
	wire on_fail;
	wire off_done;
	wire mc_hold;
	wire [2:0] mc_req;
	wire [2:0] mc;

	mps_reg_bank u_reg_bank
	(
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_wr			(i_wr),
		.i_rd			(i_rd),
		.i_addr			(i_addr),
		.i_wdata		(i_wdata),
		.o_rdata		(o_rdata),
		.o_rvalid		(o_rvalid),
		.i_sys_state	(sys_state),
		.i_pwm_en		(o_pwm_en),
		.i_on_step		(on_step),
		.i_off_step		(off_step),
		.i_fail			(fail),
		.i_ext_di		(i_ext_di),
		.i_analog_intl	(i_analog_intl),
		.i_duty_latch	(duty_latch),
		.o_cmd_valid	(cmd_valid),
		.o_cmd			(cmd),
		.o_intl_clr		(intl_clr),
		.o_ext_do_reg	(ext_do_reg)
	);

	mps_intl_monitor u_intl_monitor
	(
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_analog_intl	(i_analog_intl),
		.i_duty_intl	(i_duty_intl),
		.i_ext_di		(i_ext_di),
		.i_intl_clr		(intl_clr),
		.o_duty_latch	(duty_latch),
		.o_intl_flag	(o_intl_flag)
	);

	mps_system_fsm u_system_fsm
	(
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_cmd_valid	(cmd_valid),
		.i_cmd			(cmd),
		.i_intl_flag	(o_intl_flag),
		.i_on_done		(on_done),
		.i_on_fail		(on_fail),
		.i_mc_req		(mc_req),
		.i_off_done		(off_done),
		.i_mc_hold		(mc_hold),
		.o_sys_state	(sys_state),
		.o_on_start		(on_start),
		.o_off_start	(off_start),
		.o_seq_abort	(seq_abort),
		.o_pwm_en		(o_pwm_en),
		.o_mc			(mc)
	);

	mps_on_sequencer u_on_seq
	(
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_start		(on_start),
		.i_abort		(seq_abort),
		.i_dc_v			(i_dc_v),
		.i_ext_di		(i_ext_di),
		.o_step			(on_step),
		.o_mc_req		(mc_req),
		.o_done			(on_done),
		.o_fail_pulse	(on_fail),
		.o_fail			(fail)
	);

	mps_off_sequencer u_off_seq
	(
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_start		(off_start),
		.i_abort		(seq_abort),
		.i_dc_v			(i_dc_v),
		.o_step			(off_step),
		.o_mc_hold		(mc_hold),
		.o_done			(off_done)
	);

	assign o_ext_do = {ext_do_reg, mc};		// Host bits over the contactor drives

endmodule

`default_nettype wire

//--- mps_off_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mps_config.svh"

module mps_off_sequencer
(
	input  wire							i_clk,
	input  wire							i_rst,

	input  wire							i_start,
	input  wire							i_abort,
	input  wire [31:0]					i_dc_v,

	output mps_types_pkg::off_step_t	o_step,
	output logic						o_mc_hold,
	output logic						o_done
);

	localparam int CNT_W = $clog2(`MPS_MC_DELAY) + 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_step <= mps_types_pkg::OFF_IDLE;
			cnt <= '0;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_abort)
				o_step <= mps_types_pkg::OFF_IDLE;
			else
			begin
				case (o_step)
					mps_types_pkg::OFF_IDLE:
						if (i_start)
							o_step <= mps_types_pkg::OFF_RAMP;
					mps_types_pkg::OFF_RAMP:
						if (i_dc_v < `MPS_DCV_SAFE)			// Link discharged
						begin
							o_step <= mps_types_pkg::OFF_OPEN_MC;
							cnt <= '0;
						end
					mps_types_pkg::OFF_OPEN_MC:
						if (cnt == CNT_W'(`MPS_MC_DELAY - 1))
						begin
							o_step <= mps_types_pkg::OFF_IDLE;
							o_done <= 1'b1;
						end
						else
							cnt <= cnt + 1'b1;
					default:
						o_step <= mps_types_pkg::OFF_IDLE;
				endcase
			end
		end
	end

	assign o_mc_hold = (o_step == mps_types_pkg::OFF_RAMP);

endmodule

`default_nettype wire

//--- mps_on_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mps_config.svh"

module mps_on_sequencer
(
	input  wire							i_clk,
	input  wire							i_rst,

	input  wire							i_start,
	input  wire							i_abort,
	input  wire [31:0]					i_dc_v,
	input  wire [15:0]					i_ext_di,

	output mps_types_pkg::on_step_t		o_step,
	output logic [2:0]					o_mc_req,
	output logic						o_done,
	output logic						o_fail_pulse,
	output mps_types_pkg::fail_t		o_fail
);

	localparam int CNT_W = $clog2(`MPS_ON_TIMEOUT) + 1;

	logic [CNT_W-1:0] cnt;
	logic timeout;
	logic fan_end;

	assign timeout = (cnt == CNT_W'(`MPS_ON_TIMEOUT - 1));
	assign fan_end = (cnt == CNT_W'(`MPS_FAN_DELAY - 1));

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_step <= mps_types_pkg::ON_IDLE;
			cnt <= '0;
			o_done <= 1'b0;
			o_fail_pulse <= 1'b0;
			o_fail <= mps_types_pkg::FAIL_NONE;
		end
		else
		begin
			o_done <= 1'b0;
			o_fail_pulse <= 1'b0;
			if (i_abort)
			begin
				o_step <= mps_types_pkg::ON_IDLE;		// Failure code survives the abort
				cnt <= '0;
			end
			else
			begin
				case (o_step)
					mps_types_pkg::ON_IDLE:
						if (i_start)
						begin
							o_step <= mps_types_pkg::ON_PRECHARGE;
							cnt <= '0;
							o_fail <= mps_types_pkg::FAIL_NONE;
						end
					mps_types_pkg::ON_PRECHARGE:
						if (i_dc_v >= `MPS_DCV_READY)
						begin
							o_step <= mps_types_pkg::ON_MAIN_MC;
							cnt <= '0;
						end
						else if (timeout)
						begin
							o_step <= mps_types_pkg::ON_IDLE;
							o_fail <= mps_types_pkg::FAIL_PRECHARGE;
							o_fail_pulse <= 1'b1;
						end
						else
							cnt <= cnt + 1'b1;
					mps_types_pkg::ON_MAIN_MC:
						if (i_ext_di[1])					// Main contactor aux contact
						begin
							o_step <= mps_types_pkg::ON_FAN;
							cnt <= '0;
						end
						else if (timeout)
						begin
							o_step <= mps_types_pkg::ON_IDLE;
							o_fail <= mps_types_pkg::FAIL_MC_FEEDBACK;
							o_fail_pulse <= 1'b1;
						end
						else
							cnt <= cnt + 1'b1;
					mps_types_pkg::ON_FAN:
						if (fan_end)
						begin
							o_step <= mps_types_pkg::ON_IDLE;
							o_done <= 1'b1;
						end
						else
							cnt <= cnt + 1'b1;
					default:
						o_step <= mps_types_pkg::ON_IDLE;
				endcase
			end
		end
	end

	// Bit 1 precharge, bit 0 main, bit 2 fan
	always_comb
	begin
		case (o_step)
			mps_types_pkg::ON_PRECHARGE:	o_mc_req = 3'b010;
			mps_types_pkg::ON_MAIN_MC:		o_mc_req = 3'b011;
			mps_types_pkg::ON_FAN:			o_mc_req = 3'b111;
			default:						o_mc_req = 3'b000;
		endcase
	end

endmodule

`default_nettype wire

//--- mps_system_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mps_system_fsm
(
	input  wire							i_clk,
	input  wire							i_rst,

	input  wire							i_cmd_valid,
	input  mps_types_pkg::cmd_t			i_cmd,
	input  wire							i_intl_flag,

	input  wire							i_on_done,
	input  wire							i_on_fail,
	input  wire [2:0]					i_mc_req,
	input  wire							i_off_done,
	input  wire							i_mc_hold,

	output mps_types_pkg::sys_state_t	o_sys_state,
	output logic						o_on_start,
	output logic						o_off_start,
	output logic						o_seq_abort,
	output logic						o_pwm_en,
	output logic [2:0]					o_mc
);

	mps_types_pkg::sys_state_t state;
	mps_types_pkg::sys_state_t state_nx;
	logic cmd_ready;
	logic cmd_on;
	logic cmd_off;
	logic cmd_clr;

	assign cmd_ready = i_cmd_valid && (i_cmd == mps_types_pkg::CMD_READY);
	assign cmd_on = i_cmd_valid && (i_cmd == mps_types_pkg::CMD_OP_ON);
	assign cmd_off = i_cmd_valid && (i_cmd == mps_types_pkg::CMD_OP_OFF);
	assign cmd_clr = i_cmd_valid && (i_cmd == mps_types_pkg::CMD_INTL_CLR);

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			state <= mps_types_pkg::SYS_OFF;
		else
			state <= state_nx;
	end

	always_comb
	begin
		state_nx = state;
		case (state)
			mps_types_pkg::SYS_OFF:
				if (cmd_ready)
					state_nx = mps_types_pkg::SYS_READY;
			mps_types_pkg::SYS_READY:
				if (i_intl_flag)
					state_nx = mps_types_pkg::SYS_INTL;
				else if (cmd_on)
					state_nx = mps_types_pkg::SYS_ON_SEQ;
			mps_types_pkg::SYS_ON_SEQ:
				if (i_intl_flag || i_on_fail)
					state_nx = mps_types_pkg::SYS_INTL;
				else if (i_on_done)
					state_nx = mps_types_pkg::SYS_RUN;
			mps_types_pkg::SYS_RUN:
				if (i_intl_flag)
					state_nx = mps_types_pkg::SYS_INTL;
				else if (cmd_off)
					state_nx = mps_types_pkg::SYS_OFF_SEQ;
			mps_types_pkg::SYS_OFF_SEQ:
				if (i_intl_flag)
					state_nx = mps_types_pkg::SYS_INTL;
				else if (i_off_done)
					state_nx = mps_types_pkg::SYS_OFF;
			mps_types_pkg::SYS_INTL:
				if (cmd_clr)
					state_nx = mps_types_pkg::SYS_OFF;
			default:
				state_nx = mps_types_pkg::SYS_OFF;
		endcase
	end

	// Starts fire on the edge that enters the sequence state
	assign o_on_start = (state == mps_types_pkg::SYS_READY) && !i_intl_flag && cmd_on;
	assign o_off_start = (state == mps_types_pkg::SYS_RUN) && !i_intl_flag && cmd_off;
	assign o_seq_abort = (state == mps_types_pkg::SYS_INTL);

	assign o_sys_state = state;
	assign o_pwm_en = (state == mps_types_pkg::SYS_RUN);

	always_comb
	begin
		case (state)
			mps_types_pkg::SYS_ON_SEQ:	o_mc = i_mc_req;
			mps_types_pkg::SYS_RUN:		o_mc = 3'b111;
			mps_types_pkg::SYS_OFF_SEQ:	o_mc = i_mc_hold ? 3'b111 : 3'b000;
			default:					o_mc = 3'b000;		// Open in OFF, READY and INTL
		endcase
	end

endmodule

`default_nettype wire

//--- mps_intl_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module mps_intl_monitor
(
	input  wire			i_clk,
	input  wire			i_rst,

	input  wire [17:0]	i_analog_intl,
	input  wire			i_duty_intl,
	input  wire [15:0]	i_ext_di,
	input  wire			i_intl_clr,

	output logic		o_duty_latch,
	output logic		o_intl_flag
);

	logic intl_any;

	// Emergency stop on input 0, door and cooling switches on 4..6
	assign intl_any = (|i_analog_intl) || o_duty_latch || i_ext_di[0] || (|i_ext_di[6:4]);

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_duty_latch <= 1'b0;
			o_intl_flag <= 1'b0;
		end
		else
		begin
			if (i_intl_clr)
				o_duty_latch <= 1'b0;		// Clear wins over a new trip
			else if (i_duty_intl)
				o_duty_latch <= 1'b1;
			o_intl_flag <= intl_any;
		end
	end

endmodule

`default_nettype wire

//--- mps_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mps_config.svh"

module mps_reg_bank
(
	input  wire							i_clk,
	input  wire							i_rst,

	input  wire							i_wr,
	input  wire							i_rd,
	input  wire [`MPS_ADDR_W-1:0]		i_addr,
	input  wire [`MPS_DATA_W-1:0]		i_wdata,
	output logic [`MPS_DATA_W-1:0]		o_rdata,
	output logic						o_rvalid,

	input  mps_types_pkg::sys_state_t	i_sys_state,
	input  wire							i_pwm_en,
	input  mps_types_pkg::on_step_t		i_on_step,
	input  mps_types_pkg::off_step_t	i_off_step,
	input  mps_types_pkg::fail_t		i_fail,
	input  wire [15:0]					i_ext_di,
	input  wire [17:0]					i_analog_intl,
	input  wire							i_duty_latch,

	output logic						o_cmd_valid,
	output mps_types_pkg::cmd_t			o_cmd,
	output logic						o_intl_clr,
	output logic [4:0]					o_ext_do_reg
);

	mps_regs_pkg::reg_addr_t addr;
	logic [`MPS_DATA_W-1:0] rd_word;
	logic wr_cmd;

	assign addr = mps_regs_pkg::reg_addr_t'(i_addr);
	assign wr_cmd = i_wr && (addr == mps_regs_pkg::REG_CMD);

	// Strobes and the output latch
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_cmd_valid <= 1'b0;
			o_intl_clr <= 1'b0;
			o_rvalid <= 1'b0;
			o_ext_do_reg <= '0;
		end
		else
		begin
			o_cmd_valid <= wr_cmd;
			o_intl_clr <= wr_cmd && (i_wdata[2:0] == mps_types_pkg::CMD_INTL_CLR);
			o_rvalid <= i_rd;
			if (i_wr && (addr == mps_regs_pkg::REG_EXT_DO))
				o_ext_do_reg <= i_wdata[4:0];
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (wr_cmd)
			o_cmd <= mps_types_pkg::cmd_t'(i_wdata[2:0]);
		if (i_rd)
			o_rdata <= rd_word;
	end

	always_comb
	begin
		rd_word = '0;						// Unmapped and write-only read as zero
		case (addr)
			mps_regs_pkg::REG_EXT_DO:	rd_word[4:0] = o_ext_do_reg;
			mps_regs_pkg::REG_STATUS:
			begin
				rd_word[2:0] = i_sys_state;
				rd_word[8] = i_pwm_en;
			end
			mps_regs_pkg::REG_SEQ:
			begin
				rd_word[3:0] = i_on_step;
				rd_word[7:4] = i_off_step;
				rd_word[11:8] = i_fail;
			end
			mps_regs_pkg::REG_DIG_INTL:	rd_word[15:0] = i_ext_di;
			mps_regs_pkg::REG_ANA_INTL:
			begin
				rd_word[17:0] = i_analog_intl;
				rd_word[18] = i_duty_latch;
			end
			default:					rd_word = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- mps_regs_pkg.sv
`default_nettype none

package mps_regs_pkg;

	// Host register map in word addresses
	typedef enum logic [4:0] {
		REG_CMD			= 5'd0,		// Write only with cmd_t in bits 2:0
		REG_EXT_DO		= 5'd1,		// External output latch
		REG_STATUS		= 5'd2,
		REG_SEQ			= 5'd3,
		REG_DIG_INTL	= 5'd4,
		REG_ANA_INTL	= 5'd5
	} reg_addr_t;

endpackage

`default_nettype wire

//--- mps_types_pkg.sv
`default_nettype none

package mps_types_pkg;

	typedef enum logic [2:0] {
		SYS_OFF		= 3'd0,
		SYS_READY	= 3'd1,
		SYS_ON_SEQ	= 3'd2,
		SYS_RUN		= 3'd3,
		SYS_OFF_SEQ	= 3'd4,
		SYS_INTL	= 3'd5
	} sys_state_t;

	typedef enum logic [2:0] {
		CMD_NONE		= 3'd0,
		CMD_READY		= 3'd1,
		CMD_OP_ON		= 3'd2,
		CMD_OP_OFF		= 3'd3,
		CMD_INTL_CLR	= 3'd4
	} cmd_t;

	typedef enum logic [3:0] {
		ON_IDLE			= 4'd0,
		ON_PRECHARGE	= 4'd1,
		ON_MAIN_MC		= 4'd2,
		ON_FAN			= 4'd3
	} on_step_t;

	typedef enum logic [3:0] {
		OFF_IDLE		= 4'd0,
		OFF_RAMP		= 4'd1,
		OFF_OPEN_MC		= 4'd2
	} off_step_t;

	typedef enum logic [3:0] {
		FAIL_NONE			= 4'd0,
		FAIL_PRECHARGE		= 4'd1,
		FAIL_MC_FEEDBACK	= 4'd2
	} fail_t;

endpackage

`default_nettype wire

//--- mps_config.svh
`ifndef MPS_CONFIG_SVH
`define MPS_CONFIG_SVH

// Host register port
`define MPS_ADDR_W		5
`define MPS_DATA_W		32

// DC link thresholds in ADC counts
`define MPS_DCV_READY	1000		// Precharge complete
`define MPS_DCV_SAFE	50			// Safe to open contactors

// Sequencer delays in clock cycles
`define MPS_ON_TIMEOUT	64			// Longest power-up step
`define MPS_FAN_DELAY	8
`define MPS_MC_DELAY	8

`endif
